//--- testbench/dcache_stim.txt
# op addr wdata strb expected_rdata (hex)
# expected_rdata is checked on R lines only
R 00000100 00000000 f 00000100
R 00000104 00000000 f 00000104
W 00000108 aabbccdd 5 00000000
R 00000108 00000000 f 00bb01dd
R 00000180 00000000 f 00000180
R 00000108 00000000 f 00bb01dd
W a0000010 12345678 3 00000000
R a0000010 00000000 f a0005678
R 0000010c 00000000 f 0000010c
R a0000024 00000000 f a0000024
W 00000110 11223344 f 00000000
W 00000290 55667788 c 00000000
R 00000110 00000000 f 11223344
R 00000290 00000000 f 55660290
R 00000114 00000000 f 00000114
R 00000f3c 00000000 f 00000f3c
W 00000f30 deadbeef f 00000000
R 00000f30 00000000 f deadbeef
R 00001f30 00000000 f 00001f30
R 00000f30 00000000 f deadbeef
W 00000f34 ffffffff 0 00000000
R 00001f34 00000000 f 00001f34
R 00000f34 00000000 f 00000f34

//--- dcache.f
rtl/dcache_cfg_pkg.sv
rtl/dcache_ctrl_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_mem_port.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/tb_dcache_assert.sv
testbench/tb_dcache.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv testbench/*.sv)

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache

obj_dir/Vtb_dcache: $(SRCS) dcache.f
	verilator --binary --timing --assert --top-module tb_dcache -f dcache.f -o Vtb_dcache

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- testbench/tb_dcache.sv
module tb_dcache;
  import dcache_cfg_pkg::*;

  localparam int OFF_W   = $clog2(DEF_LINE_WORDS);
  localparam int IDX_W   = $clog2(DEF_NUM_LINES);
  localparam int TAG_W   = 32 - IDX_W - OFF_W - 2;
  localparam int TIMEOUT = 200;  // cycles per access

  logic        clk = 1'b0;
  logic        rst;
  logic        cpu_req;
  logic        cpu_we;
  addr_t       cpu_addr;
  word_t       cpu_wdata;
  strb_t       cpu_strb;
  logic        cpu_ready;
  word_t       cpu_rdata;
  logic        mem_req;
  logic        mem_we;
  addr_t       mem_addr;
  word_t       mem_wdata;
  strb_t       mem_strb;
  logic        mem_ack = 1'b0;
  word_t       mem_rdata = '0;
  logic [31:0] rng = 32'h2cc08b4a;
  int          ack_wait = 0;

  // memory model whose unwritten words read back their own address
  word_t mem [addr_t];
  addr_t beat_addr [$];
  logic  beat_we [$];
  strb_t beat_strb [$];
  word_t beat_wdata [$];

  // coherent image of every cpu write
  word_t ref_mem [addr_t];

  // expected tag state
  logic             sh_valid [DEF_NUM_LINES];
  logic             sh_dirty [DEF_NUM_LINES];
  logic [TAG_W-1:0] sh_tag [DEF_NUM_LINES];

  dcache_top #(
    .NUM_LINES (DEF_NUM_LINES),
    .LINE_WORDS(DEF_LINE_WORDS)
  ) dcache_top_i (
    .clk        (clk),
    .rst        (rst),
    .cpu_req_i  (cpu_req),
    .cpu_we_i   (cpu_we),
    .cpu_addr_i (cpu_addr),
    .cpu_wdata_i(cpu_wdata),
    .cpu_strb_i (cpu_strb),
    .cpu_ready_o(cpu_ready),
    .cpu_rdata_o(cpu_rdata),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_strb_o (mem_strb),
    .mem_ack_i  (mem_ack),
    .mem_rdata_i(mem_rdata)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t mem_peek(input addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (mem.exists(wa)) return mem[wa];
    return wa;
  endfunction

  function automatic word_t coherent_word(input addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (ref_mem.exists(wa)) return ref_mem[wa];
    return wa;
  endfunction

  // acks after 0 to 3 idle cycles and stores a write beat on its ack
  always @(negedge clk) begin
    word_t merged;
    addr_t wa;
    mem_ack = 1'b0;
    if (!rst && mem_req) begin
      if (ack_wait > 0) begin
        ack_wait = ack_wait - 1;
      end else begin
        wa        = {mem_addr[31:2], 2'b00};
        merged    = mem_peek(wa);
        mem_rdata = merged;
        if (mem_we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_strb[b]) merged[8*b +: 8] = mem_wdata[8*b +: 8];
          end
          mem[wa] = merged;
        end
        beat_addr.push_back(mem_addr);
        beat_we.push_back(mem_we);
        beat_strb.push_back(mem_strb);
        beat_wdata.push_back(mem_wdata);
        rng      = xorshift32(rng);
        ack_wait = int'(rng[1:0]);
        mem_ack  = 1'b1;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) abort_run($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) abort_run($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) abort_run($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) abort_run($sformatf("Fail %0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic run_access(input byte op, input addr_t addr, input word_t wdata,
                            input strb_t strb, input word_t exp_rdata);
    int               idx;
    int               first;
    int               cycles;
    int               n_exp;
    logic [TAG_W-1:0] tag;
    addr_t            old_base;
    addr_t            new_base;
    logic             unc;
    logic             hit;
    logic             evict;
    word_t            merged;
    idx      = int'(addr[OFF_W+2 +: IDX_W]);
    tag      = addr[31 -: TAG_W];
    old_base = {sh_tag[idx], addr[OFF_W+2 +: IDX_W], {(OFF_W+2){1'b0}}};
    new_base = {addr[31 -: (TAG_W+IDX_W)], {(OFF_W+2){1'b0}}};
    unc      = (addr[31:28] == UNCACHED_HI);
    hit      = sh_valid[idx] && (sh_tag[idx] == tag);
    evict    = !hit && sh_valid[idx] && sh_dirty[idx];
    @(negedge clk);
    first     = beat_addr.size();
    cpu_req   = 1'b1;
    cpu_we    = (op == "W");
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_strb  = strb;
    @(negedge clk);
    cycles = 1;
    while (!cpu_ready) begin
      if (cycles >= TIMEOUT) abort_run($sformatf("no cpu_ready_o for access at %h", addr));
      @(negedge clk);
      cycles++;
    end
    if (op == "R") check_word("cpu_rdata_o", cpu_rdata, exp_rdata);
    if (unc) begin
      check_count("uncached beats", beat_addr.size() - first, 1);
      check_addr("mem_addr_o", beat_addr[first], addr);
      check_strb("mem_strb_o", beat_strb[first], strb);
      check_count("mem_we_o", int'(beat_we[first]), int'(cpu_we));
      if (op == "W") check_word("mem_wdata_o", beat_wdata[first], wdata);
    end else if (hit) begin
      check_count("hit beats", beat_addr.size() - first, 0);
      check_count("hit latency", cycles, 1);
    end else begin
      n_exp = evict ? 2 * DEF_LINE_WORDS : DEF_LINE_WORDS;
      check_count("miss beats", beat_addr.size() - first, n_exp);
      for (int i = 0; i < n_exp; i++) begin
        if (evict && i < DEF_LINE_WORDS) begin
          check_addr("evict mem_addr_o", beat_addr[first+i], old_base + addr_t'(4 * i));
          check_count("evict mem_we_o", int'(beat_we[first+i]), 1);
          check_strb("evict mem_strb_o", beat_strb[first+i], 4'hF);
          check_word("evict mem_wdata_o", beat_wdata[first+i],
                     coherent_word(old_base + addr_t'(4 * i)));
        end else begin
          check_addr("refill mem_addr_o", beat_addr[first+i],
                     new_base + addr_t'(4 * (i % DEF_LINE_WORDS)));
          check_count("refill mem_we_o", int'(beat_we[first+i]), 0);
        end
      end
      sh_valid[idx] = 1'b1;  // refilled clean
      sh_dirty[idx] = 1'b0;
      sh_tag[idx]   = tag;
    end
    if (!unc && op == "W" && strb != '0) sh_dirty[idx] = 1'b1;
    if (op == "W") begin
      merged = coherent_word(addr);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
      end
      ref_mem[{addr[31:2], 2'b00}] = merged;
    end
  endtask

  initial begin
    int    fd;
    int    n_fields;
    int    n_acc;
    string line;
    byte   op;
    addr_t addr;
    word_t wdata;
    strb_t strb;
    word_t exp_rdata;
    rst       = 1'b1;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_strb  = '0;
    n_acc     = 0;
    for (int i = 0; i < DEF_NUM_LINES; i++) begin
      sh_valid[i] = 1'b0;
      sh_dirty[i] = 1'b0;
      sh_tag[i]   = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fd = $fopen("testbench/dcache_stim.txt", "r");
    if (fd == 0) abort_run("cannot open testbench/dcache_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        n_fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, strb, exp_rdata);
        if (n_fields != 5) abort_run({"malformed line in stim file: ", line});
        run_access(op, addr, wdata, strb, exp_rdata);
        n_acc++;
      end
    end
    $fclose(fd);
    @(negedge clk);
    cpu_req = 1'b0;
    repeat (2) @(negedge clk);
    if (n_acc == 0) begin
      abort_run("stim file held no accesses");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- testbench/tb_dcache_assert.sv
module tb_dcache_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  req_i,
  input logic                  we_i,
  input dcache_cfg_pkg::addr_t addr_i,
  input dcache_cfg_pkg::word_t wdata_i,
  input dcache_cfg_pkg::strb_t strb_i,
  input logic                  ack_i,
  input logic                  ready_i
);

  // request fields frozen until acked
  assert property (@(posedge clk) disable iff (rst)
    (req_i && !ack_i) |=> (req_i && $stable(we_i) && $stable(addr_i)
                           && $stable(wdata_i) && $stable(strb_i)))
    else $error("memory request changed before ack");

  assert property (@(posedge clk) disable iff (rst) ready_i |=> !ready_i)
    else $error("cpu ready held for two cycles");

  assert property (@(posedge clk) $fell(rst) |-> (!req_i && !ready_i))
    else $error("request or ready active right after reset");

endmodule

bind dcache_mem_port tb_dcache_assert mem_chk_i (
  .clk(clk), .rst(rst), .req_i(mem_req_o), .we_i(mem_we_o), .addr_i(mem_addr_o),
  .wdata_i(mem_wdata_o), .strb_i(mem_strb_o), .ack_i(mem_ack_i), .ready_i(1'b0)
);

bind dcache_ctrl tb_dcache_assert ctrl_chk_i (
  .clk(clk), .rst(rst), .req_i(1'b0), .we_i(1'b0), .addr_i('0),
  .wdata_i('0), .strb_i('0), .ack_i(1'b0), .ready_i(cpu_ready_o)
);

//--- rtl/dcache_top.sv
module dcache_top #(
  parameter int NUM_LINES  = dcache_cfg_pkg::DEF_NUM_LINES,
  parameter int LINE_WORDS = dcache_cfg_pkg::DEF_LINE_WORDS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cpu_req_i,
  input  logic                  cpu_we_i,
  input  dcache_cfg_pkg::addr_t cpu_addr_i,
  input  dcache_cfg_pkg::word_t cpu_wdata_i,
  input  dcache_cfg_pkg::strb_t cpu_strb_i,
  output logic                  cpu_ready_o,
  output dcache_cfg_pkg::word_t cpu_rdata_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output dcache_cfg_pkg::addr_t mem_addr_o,
  output dcache_cfg_pkg::word_t mem_wdata_o,
  output dcache_cfg_pkg::strb_t mem_strb_o,
  input  logic                  mem_ack_i,
  input  dcache_cfg_pkg::word_t mem_rdata_i
);
  import dcache_cfg_pkg::*;
  import dcache_ctrl_pkg::*;

  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

  mem_cmd_e         mem_cmd;
  logic             hit;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  logic [OFF_W-1:0] beat_idx;
  logic             beat_ack;  // acked refill beat from the port
  logic             done;
  logic             tag_we;
  logic             dirty_set;
  logic             cpu_we_line;
  logic             refill_we;
  word_t            line_rdata;
  word_t            evict_rdata;

  dcache_ctrl ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .cpu_we_i      (cpu_we_i),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_strb_i    (cpu_strb_i),
    .hit_i         (hit),
    .victim_dirty_i(victim_dirty),
    .beat_i        (beat_ack),
    .done_i        (done),
    .mem_rdata_i   (mem_rdata_i),
    .line_rdata_i  (line_rdata),
    .mem_cmd_o     (mem_cmd),
    .tag_we_o      (tag_we),
    .dirty_set_o   (dirty_set),
    .cpu_we_line_o (cpu_we_line),
    .refill_we_o   (refill_we),
    .cpu_ready_o   (cpu_ready_o),
    .cpu_rdata_o   (cpu_rdata_o)
  );

  dcache_tag_store #(
    .NUM_LINES (NUM_LINES),
    .LINE_WORDS(LINE_WORDS)
  ) tag_store_i (
    .clk           (clk),
    .rst           (rst),
    .addr_i        (cpu_addr_i),
    .tag_we_i      (tag_we),
    .dirty_set_i   (dirty_set),
    .hit_o         (hit),
    .victim_dirty_o(victim_dirty),
    .victim_tag_o  (victim_tag)
  );

  dcache_data_store #(
    .NUM_LINES (NUM_LINES),
    .LINE_WORDS(LINE_WORDS)
  ) data_store_i (
    .clk          (clk),
    .addr_i       (cpu_addr_i),
    .beat_i       (beat_idx),
    .cpu_we_line_i(cpu_we_line),
    .cpu_strb_i   (cpu_strb_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .refill_we_i  (refill_we),
    .mem_rdata_i  (mem_rdata_i),
    .line_rdata_o (line_rdata),
    .evict_rdata_o(evict_rdata)
  );

  dcache_mem_port #(
    .NUM_LINES (NUM_LINES),
    .LINE_WORDS(LINE_WORDS)
  ) mem_port_i (
    .clk          (clk),
    .rst          (rst),
    .mem_cmd_i    (mem_cmd),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .cpu_strb_i   (cpu_strb_i),
    .victim_tag_i (victim_tag),
    .evict_rdata_i(evict_rdata),
    .mem_ack_i    (mem_ack_i),
    .beat_o       (beat_idx),
    .done_o       (done),
    .refill_we_o  (beat_ack),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_strb_o   (mem_strb_o)
  );

endmodule

//--- rtl/dcache_ctrl.sv
module dcache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cpu_req_i,
  input  logic                       cpu_we_i,
  input  dcache_cfg_pkg::addr_t      cpu_addr_i,
  input  dcache_cfg_pkg::strb_t      cpu_strb_i,
  input  logic                       hit_i,
  input  logic                       victim_dirty_i,
  input  logic                       beat_i,
  input  logic                       done_i,
  input  dcache_cfg_pkg::word_t      mem_rdata_i,
  input  dcache_cfg_pkg::word_t      line_rdata_i,
  output dcache_ctrl_pkg::mem_cmd_e  mem_cmd_o,
  output logic                       tag_we_o,
  output logic                       dirty_set_o,
  output logic                       cpu_we_line_o,
  output logic                       refill_we_o,
  output logic                       cpu_ready_o,
  output dcache_cfg_pkg::word_t      cpu_rdata_o
);
  import dcache_cfg_pkg::*;
  import dcache_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  word_t       unc_rdata_q;
  logic        is_unc;
  logic        line_write;

  // held stable by the cpu until ready, so safe to decode every cycle
  assign is_unc = (cpu_addr_i[31:28] == UNCACHED_HI);

  // write hit with at least one byte enabled
  assign line_write = (state_q == LOOKUP_DONE) && cpu_we_i && !is_unc && (|cpu_strb_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_req_i) begin
          if (is_unc) begin
            state_d = cpu_we_i ? UNC_WRITE : UNC_READ;
          end else if (hit_i) begin
            state_d = LOOKUP_DONE;
          end else if (victim_dirty_i) begin
            state_d = EVICT;
          end else begin
            state_d = REFILL;
          end
        end
      end
      LOOKUP_DONE: state_d = IDLE;
      EVICT: begin
        if (done_i) state_d = REFILL;
      end
      REFILL: begin
        if (done_i) state_d = IDLE;  // lookup again, now hits
      end
      UNC_READ, UNC_WRITE: begin
        if (done_i) state_d = LOOKUP_DONE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // uncached read word, captured on the ack
  always_ff @(posedge clk) begin
    if (state_q == UNC_READ && done_i) begin
      unc_rdata_q <= mem_rdata_i;
    end
  end

  always_comb begin
    case (state_q)
      EVICT:     mem_cmd_o = CMD_EVICT;
      REFILL:    mem_cmd_o = CMD_REFILL;
      UNC_READ:  mem_cmd_o = CMD_UNC_READ;
      UNC_WRITE: mem_cmd_o = CMD_UNC_WRITE;
      default:   mem_cmd_o = CMD_NONE;
    endcase
  end

  // refill installs the tag clean, a write hit marks it dirty
  assign tag_we_o      = (state_q == REFILL && done_i) || line_write;
  assign dirty_set_o   = (state_q == LOOKUP_DONE);
  assign cpu_we_line_o = line_write;
  assign refill_we_o   = (state_q == REFILL) && beat_i;

  assign cpu_ready_o = (state_q == LOOKUP_DONE);
  assign cpu_rdata_o = is_unc ? unc_rdata_q : line_rdata_i;

endmodule

//--- rtl/dcache_mem_port.sv
module dcache_mem_port #(
  parameter int NUM_LINES  = 8,
  parameter int LINE_WORDS = 4,
  localparam int OFF_W     = $clog2(LINE_WORDS),
  localparam int IDX_W     = $clog2(NUM_LINES),
  localparam int TAG_W     = 32 - IDX_W - OFF_W - 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  dcache_ctrl_pkg::mem_cmd_e mem_cmd_i,
  input  dcache_cfg_pkg::addr_t     cpu_addr_i,
  input  dcache_cfg_pkg::word_t     cpu_wdata_i,
  input  dcache_cfg_pkg::strb_t     cpu_strb_i,
  input  logic [TAG_W-1:0]          victim_tag_i,
  input  dcache_cfg_pkg::word_t     evict_rdata_i,
  input  logic                      mem_ack_i,
  output logic [OFF_W-1:0]          beat_o,
  output logic                      done_o,
  output logic                      refill_we_o,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output dcache_cfg_pkg::addr_t     mem_addr_o,
  output dcache_cfg_pkg::word_t     mem_wdata_o,
  output dcache_cfg_pkg::strb_t     mem_strb_o
);
  import dcache_ctrl_pkg::*;

  logic [OFF_W-1:0] beat_q;
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] cpu_tag;
  logic             burst;
  logic             ack;
  logic             last;

  assign idx     = cpu_addr_i[OFF_W+2 +: IDX_W];
  assign cpu_tag = cpu_addr_i[31 -: TAG_W];

  assign mem_req_o = (mem_cmd_i != CMD_NONE);
  assign burst     = (mem_cmd_i == CMD_EVICT) || (mem_cmd_i == CMD_REFILL);
  assign ack       = mem_req_o && mem_ack_i;
  assign last      = !burst || (beat_q == OFF_W'(LINE_WORDS - 1));

  // advances only on an acked beat, back to zero after the last one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_q <= '0;
    end else if (ack) begin
      beat_q <= last ? '0 : beat_q + 1'b1;
    end
  end

  always_comb begin
    mem_we_o    = 1'b0;
    mem_addr_o  = cpu_addr_i;
    mem_wdata_o = '0;
    mem_strb_o  = '0;
    case (mem_cmd_i)
      CMD_EVICT: begin
        mem_we_o    = 1'b1;
        mem_addr_o  = {victim_tag_i, idx, beat_q, 2'b00};
        mem_wdata_o = evict_rdata_i;
        mem_strb_o  = 4'hF;
      end
      CMD_REFILL: begin
        mem_addr_o = {cpu_tag, idx, beat_q, 2'b00};
        mem_strb_o = 4'hF;
      end
      CMD_UNC_READ: begin
        mem_strb_o = cpu_strb_i;
      end
      CMD_UNC_WRITE: begin
        mem_we_o    = 1'b1;
        mem_wdata_o = cpu_wdata_i;
        mem_strb_o  = cpu_strb_i;
      end
      default: ;
    endcase
  end

  assign beat_o      = beat_q;
  assign done_o      = ack && last;
  assign refill_we_o = ack && (mem_cmd_i == CMD_REFILL);

endmodule

//--- rtl/dcache_data_store.sv
module dcache_data_store #(
  parameter int NUM_LINES  = 8,
  parameter int LINE_WORDS = 4,
  localparam int OFF_W     = $clog2(LINE_WORDS),
  localparam int IDX_W     = $clog2(NUM_LINES)
) (
  input  logic                  clk,
  input  dcache_cfg_pkg::addr_t addr_i,
  input  logic [OFF_W-1:0]      beat_i,
  input  logic                  cpu_we_line_i,
  input  dcache_cfg_pkg::strb_t cpu_strb_i,
  input  dcache_cfg_pkg::word_t cpu_wdata_i,
  input  logic                  refill_we_i,
  input  dcache_cfg_pkg::word_t mem_rdata_i,
  output dcache_cfg_pkg::word_t line_rdata_o,
  output dcache_cfg_pkg::word_t evict_rdata_o
);
  import dcache_cfg_pkg::*;

  word_t                  lines [NUM_LINES*LINE_WORDS];
  logic [IDX_W+OFF_W-1:0] cpu_ptr;
  logic [IDX_W+OFF_W-1:0] beat_ptr;

  // {index, word offset}
  assign cpu_ptr  = addr_i[IDX_W+OFF_W+1:2];
  assign beat_ptr = {addr_i[OFF_W+2 +: IDX_W], beat_i};

  always_ff @(posedge clk) begin
    if (refill_we_i) begin
      lines[beat_ptr] <= mem_rdata_i;
    end else if (cpu_we_line_i) begin
      for (int b = 0; b < 4; b++) begin
        if (cpu_strb_i[b]) lines[cpu_ptr][8*b +: 8] <= cpu_wdata_i[8*b +: 8];
      end
    end
  end

  assign line_rdata_o  = lines[cpu_ptr];
  assign evict_rdata_o = lines[beat_ptr];  // victim shares the cpu index

endmodule

//--- rtl/dcache_tag_store.sv
module dcache_tag_store #(
  parameter int NUM_LINES  = 8,
  parameter int LINE_WORDS = 4,
  localparam int OFF_W     = $clog2(LINE_WORDS),
  localparam int IDX_W     = $clog2(NUM_LINES),
  localparam int TAG_W     = 32 - IDX_W - OFF_W - 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_cfg_pkg::addr_t addr_i,
  input  logic                  tag_we_i,
  input  logic                  dirty_set_i,
  output logic                  hit_o,
  output logic                  victim_dirty_o,
  output logic [TAG_W-1:0]      victim_tag_o
);

  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;
  logic [TAG_W-1:0]     tag_q [NUM_LINES];
  logic [IDX_W-1:0]     idx;
  logic [TAG_W-1:0]     addr_tag;

  assign idx      = addr_i[OFF_W+2 +: IDX_W];
  assign addr_tag = addr_i[31 -: TAG_W];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_we_i) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= dirty_set_i;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[idx] <= addr_tag;
    end
  end

  assign hit_o          = valid_q[idx] && (tag_q[idx] == addr_tag);
  assign victim_dirty_o = valid_q[idx] && dirty_q[idx];
  assign victim_tag_o   = tag_q[idx];  // base of the line to write back

endmodule

//--- rtl/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP_DONE,  // ready pulse, write hit lands here
    EVICT,
    REFILL,
    UNC_READ,
    UNC_WRITE
  } ctrl_state_e;

  // five commands need three bits
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_EVICT,
    CMD_REFILL,
    CMD_UNC_READ,
    CMD_UNC_WRITE
  } mem_cmd_e;

endpackage

//--- rtl/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  // bus and cpu port word
  typedef logic [31:0] word_t;

  // byte address, low two bits unused by the cache
  typedef logic [31:0] addr_t;

  // one write strobe per byte lane
  typedef logic [3:0] strb_t;

  // top nibble that selects the uncached region
  localparam logic [3:0] UNCACHED_HI = 4'hA;

  // default geometry, 8 lines of 4 words
  localparam int DEF_NUM_LINES  = 8;
  localparam int DEF_LINE_WORDS = 4;

endpackage
